// ==== all.f ====
hw/accel_pkg.sv
hw/dma_pkg.sv
hw/sync_fifo.sv
hw/beat_counter.sv
hw/dma_ctrl_fsm.sv
hw/rule_matcher.sv
hw/accel_regs.sv
hw/accel_top.sv
verif/accel_tb.sv

// ==== hw/accel_pkg.sv ====
package accel_pkg;

  // MMIO port
  localparam int io_addr_width = 8;
  localparam int io_data_width = 32;
  localparam int io_strb_width = io_data_width / 8;

  // Rule table
  localparam int rule_count     = 16;
  localparam int rule_idx_width = 4;
  localparam int rule_id_width  = 16;

  // Results waiting for software
  localparam int result_depth = 16;

  // Register byte offsets
  typedef enum logic [io_addr_width-1:0] {
    reg_ctrl   = 8'h00,
    reg_len    = 8'h04,
    reg_addr   = 8'h08,
    reg_slot   = 8'h0c,
    reg_result = 8'h10,
    reg_count  = 8'h14
  } reg_addr_e;

  // Bits of a control write
  localparam int ctrl_start_bit   = 0;
  localparam int ctrl_release_bit = 1;
  localparam int ctrl_stop_bit    = 2;

  typedef struct packed {
    logic                     found;
    logic                     stopped;
    logic [rule_id_width-1:0] rule_id;
    logic [7:0]               match_count;
    logic [7:0]               slot;
  } match_result_t;

  typedef struct packed {
    logic [31:0]              pattern;
    logic [rule_id_width-1:0] rule_id;
  } rule_entry_t;

endpackage

// ==== hw/accel_regs.sv ====
`timescale 1ns/1ps

module accel_regs (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  io_en,
  input  logic                                  io_wen,
  input  logic [accel_pkg::io_strb_width-1:0]   io_strb,
  input  logic [accel_pkg::io_addr_width-1:0]   io_addr,
  input  logic [accel_pkg::io_data_width-1:0]   io_wr_data,
  output logic [accel_pkg::io_data_width-1:0]   io_rd_data,
  output logic                                  io_rd_valid,
  output dma_pkg::dma_desc_t                    desc,
  output logic                                  start_pulse,
  output logic                                  release_pulse,
  output logic                                  stop_pulse,
  input  logic                                  desc_full,
  input  accel_pkg::match_result_t              result_head,
  input  logic                                  result_avail,
  input  logic                                  dma_busy,
  input  logic                                  result_push,
  output logic                                  error,
  input  logic                                  error_ack
);
  import accel_pkg::*;
  import dma_pkg::*;

  logic                       wr_en;
  logic                       rd_req;
  logic                       ctrl_wr;
  logic                       start_req;
  logic                       release_req;
  logic                       done_q;
  logic                       overflow_q;
  logic [len_width-1:0]       len_q;
  logic [pmem_addr_width-1:0] addr_q;
  logic [7:0]                 slot_q;

  assign wr_en   = io_en && io_wen;
  assign rd_req  = io_en && !io_wen;
  assign ctrl_wr = wr_en && (io_addr == reg_ctrl) && io_strb[0];

  // Requests are registered, then gated by the FIFO levels at issue time
  assign start_pulse   = start_req && !desc_full;
  assign release_pulse = release_req && result_avail;
  assign desc          = '{addr: addr_q, len: len_q, slot: slot_q};
  assign error         = overflow_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      start_req   <= 1'b0;
      release_req <= 1'b0;
      stop_pulse  <= 1'b0;
      len_q       <= '0;
      addr_q      <= '0;
      slot_q      <= '0;
    end else begin
      start_req   <= ctrl_wr && io_wr_data[ctrl_start_bit];
      release_req <= ctrl_wr && io_wr_data[ctrl_release_bit];
      stop_pulse  <= ctrl_wr && io_wr_data[ctrl_stop_bit];
      if (wr_en) begin
        case (io_addr)
          reg_len: if (io_strb[0]) len_q <= io_wr_data[len_width-1:0];
          reg_addr: begin
            if (io_strb[0]) addr_q[7:0] <= io_wr_data[7:0];
            if (io_strb[1]) addr_q[pmem_addr_width-1:8] <= io_wr_data[pmem_addr_width-1:8];
          end
          reg_slot: if (io_strb[0]) slot_q <= io_wr_data[7:0];
          default: ;
        endcase
      end
    end
  end

  // Sticky flags, a new event wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      done_q     <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      if (result_push) begin
        done_q <= 1'b1;
      end else if (ctrl_wr && io_wr_data[ctrl_start_bit]) begin
        done_q <= 1'b0;
      end
      if (start_req && desc_full) begin
        overflow_q <= 1'b1;
      end else if (error_ack) begin
        overflow_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
    end else begin
      io_rd_valid <= rd_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      case (io_addr)
        reg_ctrl:   io_rd_data <= io_data_width'({overflow_q, done_q, dma_busy, result_avail});
        reg_len:    io_rd_data <= io_data_width'(len_q);
        reg_addr:   io_rd_data <= io_data_width'(addr_q);
        reg_slot:   io_rd_data <= io_data_width'(slot_q);
        reg_result: io_rd_data <= {result_head.found, result_head.stopped, 6'd0,
                                   result_head.slot, result_head.rule_id};
        reg_count:  io_rd_data <= io_data_width'(result_head.match_count);
        default:    io_rd_data <= '0;
      endcase
    end
  end

  // Every read answers once, one cycle later
  a_rd_valid_single: assert property (@(posedge clk) disable iff (rst)
    (io_rd_valid && $past(io_rd_valid)) |-> ($past(rd_req) && $past(rd_req, 2)));

endmodule

// ==== hw/accel_top.sv ====
`timescale 1ns/1ps

module accel_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 io_en,
  input  logic                                 io_wen,
  input  logic [accel_pkg::io_strb_width-1:0]  io_strb,
  input  logic [accel_pkg::io_addr_width-1:0]  io_addr,
  input  logic [accel_pkg::io_data_width-1:0]  io_wr_data,
  output logic [accel_pkg::io_data_width-1:0]  io_rd_data,
  output logic                                 io_rd_valid,
  input  logic                                 rule_wr_en,
  input  logic [accel_pkg::rule_idx_width-1:0] rule_wr_addr,
  input  accel_pkg::rule_entry_t               rule_wr_data,
  output logic                                 mem_rd_en,
  output logic [dma_pkg::pmem_addr_width-1:0]  mem_rd_addr,
  input  logic [dma_pkg::pmem_data_width-1:0]  mem_rd_data,
  output logic                                 error,
  input  logic                                 error_ack
);
  import accel_pkg::*;
  import dma_pkg::*;

  dma_desc_t     desc_in;
  dma_desc_t     desc_head;
  logic          start_pulse;
  logic          release_pulse;
  logic          stop_pulse;
  logic          desc_full;
  logic          desc_empty;
  logic          desc_pop;
  match_result_t result;
  match_result_t result_head;
  logic          result_push;
  logic          result_full;
  logic          result_empty;
  logic          dma_busy;
  logic          job_stopped;
  stream_beat_t  beat;
  logic          beat_valid;

  accel_regs regs (
    .clk (clk), .rst (rst),
    .io_en (io_en), .io_wen (io_wen), .io_strb (io_strb), .io_addr (io_addr),
    .io_wr_data (io_wr_data), .io_rd_data (io_rd_data), .io_rd_valid (io_rd_valid),
    .desc (desc_in), .start_pulse (start_pulse), .release_pulse (release_pulse),
    .stop_pulse (stop_pulse), .desc_full (desc_full), .result_head (result_head),
    .result_avail (!result_empty), .dma_busy (dma_busy), .result_push (result_push),
    .error (error), .error_ack (error_ack)
  );

  sync_fifo #(.data_t(dma_desc_t), .depth(desc_depth)) desc_fifo (
    .clk (clk), .rst (rst),
    .push (start_pulse), .din (desc_in),
    .pop (desc_pop), .dout (desc_head),
    .full (desc_full), .empty (desc_empty)
  );

  dma_ctrl_fsm dma (
    .clk (clk), .rst (rst),
    .desc (desc_head), .desc_avail (!desc_empty), .desc_pop (desc_pop),
    .result_full (result_full), .stop_pulse (stop_pulse),
    .mem_rd_en (mem_rd_en), .mem_rd_addr (mem_rd_addr), .mem_rd_data (mem_rd_data),
    .beat (beat), .beat_valid (beat_valid), .stopped (job_stopped), .busy (dma_busy)
  );

  // Slot of the running job comes from the descriptor at the FIFO head
  rule_matcher matcher (
    .clk (clk), .rst (rst),
    .rule_wr_en (rule_wr_en), .rule_wr_addr (rule_wr_addr), .rule_wr_data (rule_wr_data),
    .beat (beat), .beat_valid (beat_valid),
    .job_slot (desc_head.slot), .job_stopped (job_stopped),
    .result (result), .result_push (result_push)
  );

  sync_fifo #(.data_t(match_result_t), .depth(result_depth)) result_fifo (
    .clk (clk), .rst (rst),
    .push (result_push), .din (result),
    .pop (release_pulse), .dout (result_head),
    .full (result_full), .empty (result_empty)
  );

endmodule

// ==== hw/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                load,
  input  logic [dma_pkg::pmem_addr_width-1:0] base_addr,
  input  logic [dma_pkg::len_width-1:0]       len,
  input  logic                                step,
  output logic [dma_pkg::pmem_addr_width-1:0] addr,
  output logic                                final_word
);
  import dma_pkg::*;

  // Words still to issue in this job
  logic [len_width-1:0] remaining;

  assign final_word = step && (remaining == len_width'(1));

  always_ff @(posedge clk) begin
    if (load) begin
      addr <= base_addr;
    end else if (step) begin
      addr <= addr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
    end else if (load) begin
      // Zero length runs one word
      remaining <= (len == '0) ? len_width'(1) : len;
    end else if (step) begin
      remaining <= remaining - 1'b1;
    end
  end

  // The FSM must stop stepping once the last word is out
  a_no_wrap: assert property (@(posedge clk) disable iff (rst)
    (step && !load) |-> (remaining != '0));

endmodule

// ==== hw/dma_ctrl_fsm.sv ====
`timescale 1ns/1ps

module dma_ctrl_fsm (
  input  logic                                clk,
  input  logic                                rst,
  input  dma_pkg::dma_desc_t                  desc,
  input  logic                                desc_avail,
  output logic                                desc_pop,
  input  logic                                result_full,
  input  logic                                stop_pulse,
  output logic                                mem_rd_en,
  output logic [dma_pkg::pmem_addr_width-1:0] mem_rd_addr,
  input  logic [dma_pkg::pmem_data_width-1:0] mem_rd_data,
  output dma_pkg::stream_beat_t               beat,
  output logic                                beat_valid,
  output logic                                stopped,
  output logic                                busy
);
  import dma_pkg::*;

  dma_state_e state;
  logic       job_start;
  logic       final_word;
  logic       issue_last;
  logic       last_q;

  // New job only when the result FIFO has room for its result
  assign job_start = (state == dma_idle) && desc_avail && !result_full;
  assign mem_rd_en = (state == dma_read);
  assign issue_last = final_word || stopped || stop_pulse;
  // Descriptor stays at the FIFO head during its job so the matcher sees its slot
  assign desc_pop = (state == dma_wait_result);
  assign busy = (state != dma_idle);

  // Read data arrives one cycle after the issue
  assign beat = '{data: mem_rd_data, last: last_q};

  beat_counter counter (
    .clk        (clk),
    .rst        (rst),
    .load       (job_start),
    .base_addr  (desc.addr),
    .len        (desc.len),
    .step       (mem_rd_en),
    .addr       (mem_rd_addr),
    .final_word (final_word)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= dma_idle;
      stopped    <= 1'b0;
      beat_valid <= 1'b0;
      last_q     <= 1'b0;
    end else begin
      beat_valid <= mem_rd_en;
      last_q     <= mem_rd_en && issue_last;
      case (state)
        dma_idle: begin
          if (job_start) begin
            // A stop landing as the job starts applies to it
            stopped <= stop_pulse;
            state   <= dma_read;
          end
        end
        dma_read: begin
          if (stop_pulse) begin
            stopped <= 1'b1;
          end
          if (issue_last) begin
            state <= dma_drain;
          end
        end
        dma_drain:       state <= dma_wait_result;
        dma_wait_result: state <= dma_idle;
        default:         state <= dma_idle;
      endcase
    end
  end

  // Reads only in dma_read and on consecutive addresses within a burst
  a_rd_in_read: assert property (@(posedge clk) disable iff (rst)
    mem_rd_en |-> (state == dma_read) &&
      (!$past(mem_rd_en) || (mem_rd_addr == $past(mem_rd_addr) + 1'b1)));

endmodule

// ==== hw/dma_pkg.sv ====
package dma_pkg;

  // Packet memory, one 32-bit word per address
  localparam int pmem_addr_width = 12;
  localparam int pmem_data_width = 32;

  // Job length in words, 0 runs as a single word
  localparam int len_width = 8;

  // Jobs waiting for the DMA
  localparam int desc_depth = 8;

  typedef struct packed {
    logic [pmem_addr_width-1:0] addr;
    logic [len_width-1:0]       len;
    logic [7:0]                 slot;
  } dma_desc_t;

  typedef struct packed {
    logic [pmem_data_width-1:0] data;
    logic                       last;
  } stream_beat_t;

  typedef enum logic [1:0] {
    dma_idle,
    dma_read,
    dma_drain,
    dma_wait_result
  } dma_state_e;

endpackage

// ==== hw/rule_matcher.sv ====
`timescale 1ns/1ps

module rule_matcher (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               rule_wr_en,
  input  logic [accel_pkg::rule_idx_width-1:0] rule_wr_addr,
  input  accel_pkg::rule_entry_t             rule_wr_data,
  input  dma_pkg::stream_beat_t              beat,
  input  logic                               beat_valid,
  input  logic [7:0]                         job_slot,
  input  logic                               job_stopped,
  output accel_pkg::match_result_t           result,
  output logic                               result_push
);
  import accel_pkg::*;

  rule_entry_t              rules [rule_count];
  logic [rule_count-1:0]    rule_valid;
  logic [rule_count-1:0]    hit;
  logic [rule_id_width-1:0] first_id;
  logic                     found_q;
  logic [rule_id_width-1:0] rule_id_q;
  logic [7:0]               count_q;
  logic                     next_found;
  logic [rule_id_width-1:0] next_id;
  logic [7:0]               next_count;

  always_ff @(posedge clk) begin
    if (rule_wr_en) begin
      rules[rule_wr_addr] <= rule_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rule_valid <= '0;
    end else if (rule_wr_en) begin
      rule_valid[rule_wr_addr] <= 1'b1;
    end
  end

  // Compare the word against all entries, lowest index wins the id
  always_comb begin
    first_id = '0;
    for (int i = 0; i < rule_count; i++) begin
      hit[i] = rule_valid[i] && (rules[i].pattern == beat.data);
    end
    for (int i = rule_count - 1; i >= 0; i--) begin
      if (hit[i]) first_id = rules[i].rule_id;
    end
  end

  always_comb begin
    next_found = found_q;
    next_id    = rule_id_q;
    next_count = count_q;
    if (|hit) begin
      // Id sticks from the first matching word
      if (!found_q) begin
        next_found = 1'b1;
        next_id    = first_id;
      end
      if (count_q != '1) next_count = count_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      found_q     <= 1'b0;
      rule_id_q   <= '0;
      count_q     <= '0;
      result_push <= 1'b0;
    end else begin
      result_push <= beat_valid && beat.last;
      if (beat_valid) begin
        found_q   <= beat.last ? 1'b0 : next_found;
        rule_id_q <= beat.last ? '0 : next_id;
        count_q   <= beat.last ? '0 : next_count;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid && beat.last) begin
      result <= '{found: next_found, stopped: job_stopped, rule_id: next_id,
                  match_count: next_count, slot: job_slot};
    end
  end

endmodule

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter type data_t = logic [31:0],
  parameter int  depth  = 8
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  data_t din,
  input  logic  pop,
  output data_t dout,
  output logic  full,
  output logic  empty
);
  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

  data_t                mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 do_push;
  logic                 do_pop;

  assign full    = (count == (ptr_width+1)'(depth));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Callers gate their strobes with the levels
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

// ==== verif/accel_tb.sv ====
`timescale 1ns/1ps

module accel_tb;
  import accel_pkg::*;
  import dma_pkg::*;

  localparam int pmem_words = 1 << pmem_addr_width;
  localparam int poll_limit = 2000;
  localparam logic [31:0] pat_a = 32'hcafe_f00d;
  localparam logic [31:0] pat_b = 32'h5eed_1234;
  localparam logic [31:0] pat_c = 32'h0bad_c0de;

  typedef logic [31:0] pmem_img_t [pmem_words];
  typedef rule_entry_t rule_tab_t [rule_count];

  logic                       clk;
  logic                       rst;
  logic                       io_en;
  logic                       io_wen;
  logic [io_strb_width-1:0]   io_strb;
  logic [io_addr_width-1:0]   io_addr;
  logic [io_data_width-1:0]   io_wr_data;
  logic [io_data_width-1:0]   io_rd_data;
  logic                       io_rd_valid;
  logic                       rule_wr_en;
  logic [rule_idx_width-1:0]  rule_wr_addr;
  rule_entry_t                rule_wr_data;
  logic                       mem_rd_en;
  logic [pmem_addr_width-1:0] mem_rd_addr;
  logic [pmem_data_width-1:0] mem_rd_data;
  logic                       error;
  logic                       error_ack;

  pmem_img_t                  pmem;
  rule_tab_t                  rule_tab;
  logic [rule_count-1:0]      rule_vld;
  match_result_t              exp_q [$];
  logic                       rd_pending = 1'b0;
  logic [pmem_addr_width-1:0] rd_addr_q;
  logic [31:0]                lcg_state;
  int                         value_errors;
  int                         timeout_errors;

  accel_top UUT (
    .clk (clk), .rst (rst),
    .io_en (io_en), .io_wen (io_wen), .io_strb (io_strb), .io_addr (io_addr),
    .io_wr_data (io_wr_data), .io_rd_data (io_rd_data), .io_rd_valid (io_rd_valid),
    .rule_wr_en (rule_wr_en), .rule_wr_addr (rule_wr_addr), .rule_wr_data (rule_wr_data),
    .mem_rd_en (mem_rd_en), .mem_rd_addr (mem_rd_addr), .mem_rd_data (mem_rd_data),
    .error (error), .error_ack (error_ack)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Packet memory, data for a read shows up in the following cycle
  always @(posedge clk) begin
    #1;
    if (rd_pending) mem_rd_data = pmem[rd_addr_q];
    rd_pending = mem_rd_en;
    rd_addr_q  = mem_rd_addr;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected result of one job, lowest matching entry gives the id
  function automatic match_result_t ref_match(input pmem_img_t mem, input rule_tab_t rules,
      input logic [rule_count-1:0] vld, input logic [pmem_addr_width-1:0] addr,
      input logic [len_width-1:0] len, input logic [7:0] slot, input logic stopped);
    match_result_t            res;
    int                       words;
    logic [31:0]              word;
    logic                     hit;
    logic [rule_id_width-1:0] id;
    res = '0;
    res.slot = slot;
    res.stopped = stopped;
    words = (len == 0) ? 1 : int'(len);
    for (int w = 0; w < words; w++) begin
      word = mem[pmem_addr_width'(int'(addr) + w)];
      hit = 1'b0;
      id = '0;
      for (int i = 0; i < rule_count; i++) begin
        if (!hit && vld[i] && rules[i].pattern == word) begin
          hit = 1'b1;
          id = rules[i].rule_id;
        end
      end
      if (hit) begin
        if (!res.found) begin
          res.found = 1'b1;
          res.rule_id = id;
        end
        if (res.match_count != 8'd255) res.match_count = res.match_count + 8'd1;
      end
    end
    return res;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input string name, input match_result_t got,
      input match_result_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic skip_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic mmio_write(input logic [io_addr_width-1:0] addr, input logic [31:0] data,
      input logic [io_strb_width-1:0] strb);
    io_en = 1'b1;
    io_wen = 1'b1;
    io_addr = addr;
    io_wr_data = data;
    io_strb = strb;
    @(posedge clk);
    #1;
    io_en = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic mmio_read(input logic [io_addr_width-1:0] addr, output logic [31:0] data);
    int waited;
    io_en = 1'b1;
    io_wen = 1'b0;
    io_addr = addr;
    @(posedge clk);
    #1;
    io_en = 1'b0;
    waited = 0;
    while (!io_rd_valid) begin
      if (waited == 4) begin
        $display("timeout at %0t ns: register read got no answer", $time);
        timeout_errors++;
        end_run();
      end
      @(posedge clk);
      #1;
      waited++;
    end
    // The answer belongs in the cycle right after the request
    if (waited != 0) begin
      value_errors++;
      $display("register read at %0t ns answered %0d cycles late", $time, waited);
    end
    data = io_rd_data;
  endtask

  task automatic wait_status(input logic [31:0] mask, input string what);
    logic [31:0] status;
    int          polls;
    polls = 0;
    mmio_read(reg_ctrl, status);
    while ((status & mask) != mask) begin
      if (polls == poll_limit) begin
        $display("timeout at %0t ns: waited too long for %s", $time, what);
        timeout_errors++;
        end_run();
      end
      polls++;
      mmio_read(reg_ctrl, status);
    end
  endtask

  task automatic load_rule(input int idx, input logic [31:0] pattern,
      input logic [rule_id_width-1:0] id);
    rule_wr_en = 1'b1;
    rule_wr_addr = rule_idx_width'(idx);
    rule_wr_data = '{pattern: pattern, rule_id: id};
    @(posedge clk);
    #1;
    rule_wr_en = 1'b0;
    rule_tab[idx] = rule_wr_data;
    rule_vld[idx] = 1'b1;
  endtask

  // Program one job and queue it, a stop write can follow right away
  task automatic submit_job(input logic [pmem_addr_width-1:0] addr,
      input logic [len_width-1:0] len, input logic [7:0] slot,
      input logic accepted, input logic stop);
    mmio_write(reg_addr, 32'(addr), 4'hf);
    mmio_write(reg_len, 32'(len), 4'hf);
    mmio_write(reg_slot, 32'(slot), 4'hf);
    mmio_write(reg_ctrl, 32'd1 << ctrl_start_bit, 4'h1);
    if (stop) mmio_write(reg_ctrl, 32'd1 << ctrl_stop_bit, 4'h1);
    if (accepted) exp_q.push_back(ref_match(pmem, rule_tab, rule_vld, addr, len, slot, stop));
  endtask

  // Read the head result, compare it in order, then release it
  task automatic drain_one();
    logic [31:0]   res_word;
    logic [31:0]   count_word;
    match_result_t got;
    match_result_t exp;
    wait_status(32'h1, "a result");
    mmio_read(reg_result, res_word);
    mmio_read(reg_count, count_word);
    got = '{found: res_word[31], stopped: res_word[30], rule_id: res_word[15:0],
            match_count: count_word[7:0], slot: res_word[23:16]};
    if (exp_q.size() == 0) begin
      value_errors++;
      $display("a result came out at %0t ns with no job left that should give it", $time);
    end else begin
      exp = exp_q.pop_front();
      check_result("result", got, exp);
    end
    check_word("reg_result zero bits", {2'b00, res_word[29:24], 24'd0}, 32'd0);
    mmio_write(reg_ctrl, 32'd1 << ctrl_release_bit, 4'h1);
    skip_cycles(2);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] status_before;
    logic [31:0] status_after;
    value_errors = 0;
    timeout_errors = 0;
    rst = 1'b1;
    io_en = 1'b0;
    io_wen = 1'b0;
    io_strb = '0;
    io_addr = '0;
    io_wr_data = '0;
    rule_wr_en = 1'b0;
    rule_wr_addr = '0;
    rule_wr_data = '0;
    mem_rd_data = '0;
    error_ack = 1'b0;
    rule_vld = '0;
    lcg_state = 32'h82ae;
    for (int a = 0; a < pmem_words; a++) begin
      lcg_state = lcg_next(lcg_state);
      pmem[a] = lcg_state;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Register readback, byte 0 of slot is left out of the second write
    mmio_read(reg_ctrl, rd);
    check_word("status after reset", rd, 32'h0);
    check_word("error after reset", 32'(error), 32'h0);
    mmio_write(reg_len, 32'h0000_005a, 4'hf);
    mmio_write(reg_addr, 32'h0000_0abc, 4'hf);
    mmio_write(reg_slot, 32'h0000_0077, 4'hf);
    mmio_write(reg_slot, 32'h0000_ff11, 4'h2);
    mmio_read(reg_len, rd);
    check_word("reg_len", rd, 32'h5a);
    mmio_read(reg_addr, rd);
    check_word("reg_addr", rd, 32'habc);
    mmio_read(reg_slot, rd);
    check_word("reg_slot", rd, 32'h77);

    // Entries 3 and 7 share a pattern
    load_rule(1, pat_b, 16'h0101);
    load_rule(3, pat_a, 16'h0303);
    load_rule(7, pat_a, 16'h0707);
    load_rule(9, pat_c, 16'h0909);
    pmem[12'h105] = pat_a;
    pmem[12'h108] = pat_b;
    pmem[12'h110] = pat_a;
    pmem[12'h11f] = pat_b;
    submit_job(12'h100, 8'd40, 8'h21, 1'b1, 1'b0);
    drain_one();

    // Random data, then a full-length job where every word matches
    submit_job(12'h400, 8'd32, 8'h22, 1'b1, 1'b0);
    drain_one();
    for (int a = 0; a < 255; a++) pmem[12'h800 + a] = pat_c;
    submit_job(12'h800, 8'd255, 8'h23, 1'b1, 1'b0);
    drain_one();

    // Jobs queued back to back
    for (int k = 0; k < 5; k++) pmem[12'h300 + 16 * k + k] = (k % 2) ? pat_a : pat_b;
    for (int k = 0; k < 5; k++) begin
      submit_job(pmem_addr_width'(12'h300 + 16 * k), len_width'(6 + k), 8'(8'h30 + k),
                 1'b1, 1'b0);
    end
    repeat (5) drain_one();

    // Fill the result FIFO, then the descriptor FIFO, then overflow
    for (int k = 0; k < 24; k += 3) pmem[12'h200 + 8 * k + k % 4] = pat_b;
    for (int k = 0; k < 16; k++) begin
      submit_job(pmem_addr_width'(12'h200 + 8 * k), 8'd4, 8'(8'h40 + k), 1'b1, 1'b0);
      wait_status(32'h4, "job done");
    end
    for (int k = 16; k < 24; k++) begin
      submit_job(pmem_addr_width'(12'h200 + 8 * k), 8'd4, 8'(8'h40 + k), 1'b1, 1'b0);
      skip_cycles(2);
      mmio_read(reg_ctrl, rd);
      check_word("overflow while descriptors fit", rd & 32'h8, 32'h0);
    end
    submit_job(12'h2c0, 8'd4, 8'h58, 1'b0, 1'b0);
    skip_cycles(2);
    check_word("error after dropped job", 32'(error), 32'h1);
    mmio_read(reg_ctrl, rd);
    check_word("overflow status", rd & 32'h8, 32'h8);
    error_ack = 1'b1;
    @(posedge clk);
    #1;
    error_ack = 1'b0;
    check_word("error after ack", 32'(error), 32'h0);
    repeat (24) drain_one();

    // Stop during a long job, then a stop while idle
    submit_job(12'ha00, 8'd200, 8'h66, 1'b1, 1'b1);
    drain_one();
    mmio_read(reg_ctrl, status_before);
    mmio_write(reg_ctrl, 32'd1 << ctrl_stop_bit, 4'h1);
    skip_cycles(3);
    mmio_read(reg_ctrl, status_after);
    check_word("status after idle stop", status_after, status_before);
    check_word("results still expected", 32'(exp_q.size()), 32'h0);

    end_run();
  end

endmodule
